// ==== source/dtu_width_pkg.sv ====
// data widths of the debug transport bridge
// vector types for register data, pc and debug instructions
// read-select flag type

package dtu_width_pkg;

  // ====================
  // widths
  // ====================
  // register data width
  parameter int XLEN = 64;
  // physical pc width
  parameter int PA_WIDTH = 40;
  // debug instruction width
  parameter int INST_WIDTH = 32;

  // ====================
  // vector types
  // ====================
  // abstract register data
  typedef logic [XLEN-1:0] xlen_t;
  // latest retired pc from the core
  typedef logic [PA_WIDTH-1:0] pa_t;
  // instruction injected by the dm
  typedef logic [INST_WIDTH-1:0] inst_t;
  // write flag, picks the read source
  typedef logic [1:0] reg_sel_t;

endpackage

// ==== source/dtu_ctrl_pkg.sv ====
// control encodings of the debug transport bridge
// have-reset fsm states
// read-select codes for the abstract register path

package dtu_ctrl_pkg;

  // have-reset fsm
  // idle and pulse are the two cycles right after reset release
  typedef enum logic [1:0] {
    IDLE       = 2'b00,
    PULSE      = 2'b01,
    HAVE_RESET = 2'b10,
    PENDING    = 2'b11
  } havereset_state_e;

  // read source codes, carried on the write flag
  // dscratch0
  parameter dtu_width_pkg::reg_sel_t SEL_DSCRATCH0 = 2'd0;
  // constant zero
  parameter dtu_width_pkg::reg_sel_t SEL_ZERO      = 2'd1;
  // latest pc, zero extended
  parameter dtu_width_pkg::reg_sel_t SEL_PC        = 2'd2;
  // satp csr
  parameter dtu_width_pkg::reg_sel_t SEL_SATP      = 2'd3;

endpackage

// ==== source/dtu_lvl_sync.sv ====
// multi-stage level synchronizer
// one shift chain per level bit, all flops reset low

`timescale 1ns/1ps

module dtu_lvl_sync #(
  parameter int WIDTH  = 3,
  parameter int STAGES = 2
) (
  input  logic             dtu_cdc_clk,
  input  logic             cpurst_b,
  input  logic [WIDTH-1:0] src_lvl,
  output logic [WIDTH-1:0] dst_lvl
);

  // stage 0 samples the dm levels
  logic [STAGES-1:0][WIDTH-1:0] sync_q;

  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      sync_q <= '0;
    end
    else
    begin
      sync_q[0] <= src_lvl;
      // shift down the chain
      for (int i = 1; i < STAGES; i++)
      begin
        sync_q[i] <= sync_q[i-1];
      end
    end
  end

  // last stage is the synchronized level
  assign dst_lvl = sync_q[STAGES-1];

endmodule

// ==== source/dtu_halt_ctrl.sv ====
// async halt wakeup and halt pulse generation
// resume pulse register toward the core
// core debug status registered back to the dm

`timescale 1ns/1ps

module dtu_halt_ctrl (
  input  logic dtu_cdc_clk,
  input  logic cpurst_b,
  input  logic async_lvl,
  input  logic dm_resume_req,
  input  logic rtu_dbgon,
  input  logic rtu_retire_vld,
  input  logic rtu_retire_debug_expt_vld,
  output logic async_halt_req_wakeup,
  output logic dtu_rtu_async_halt_req,
  output logic dtu_rtu_resume_req,
  output logic dtu_tdt_dm_halted,
  output logic dtu_tdt_dm_itr_done,
  output logic dtu_tdt_dm_retire_debug_expt_vld
);

  // delayed copies of the synced async level
  logic async_lvl_f;
  logic async_lvl_ff;

  // ====================
  // async halt edge
  // ====================
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      async_lvl_f  <= 1'b0;
      async_lvl_ff <= 1'b0;
    end
    else
    begin
      async_lvl_f  <= async_lvl;
      async_lvl_ff <= async_lvl_f;
    end
  end

  // wakeup first, halt one cycle behind
  assign async_halt_req_wakeup  = async_lvl & ~async_lvl_f;
  assign dtu_rtu_async_halt_req = async_lvl_f & ~async_lvl_ff;

  // ====================
  // resume and status
  // ====================
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      dtu_rtu_resume_req               <= 1'b0;
      dtu_tdt_dm_halted                <= 1'b0;
      dtu_tdt_dm_itr_done              <= 1'b0;
      dtu_tdt_dm_retire_debug_expt_vld <= 1'b0;
    end
    else
    begin
      dtu_rtu_resume_req               <= dm_resume_req;
      dtu_tdt_dm_halted                <= rtu_dbgon;
      // only retires in debug mode finish an injected instruction
      dtu_tdt_dm_itr_done              <= rtu_retire_vld & rtu_dbgon;
      dtu_tdt_dm_retire_debug_expt_vld <= rtu_retire_debug_expt_vld;
    end
  end

endmodule

// ==== source/dtu_havereset_fsm.sv ====
// have-reset state machine
// reports have-reset to the dm until it is acknowledged

`timescale 1ns/1ps

module dtu_havereset_fsm (
  input  logic dtu_cdc_clk,
  input  logic cpurst_b,
  input  logic dm_ack_havereset,
  output logic dtu_tdt_dm_havereset
);

  dtu_ctrl_pkg::havereset_state_e cur_state;
  dtu_ctrl_pkg::havereset_state_e next_state;

  // state register
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      cur_state <= dtu_ctrl_pkg::IDLE;
    end
    else
    begin
      cur_state <= next_state;
    end
  end

  // next state
  // walks idle, pulse, have_reset after release, then waits for the ack
  always_comb
  begin
    case (cur_state)
      dtu_ctrl_pkg::IDLE:       next_state = dtu_ctrl_pkg::PULSE;
      dtu_ctrl_pkg::PULSE:      next_state = dtu_ctrl_pkg::HAVE_RESET;
      dtu_ctrl_pkg::HAVE_RESET:
      begin
        if (dm_ack_havereset)
          next_state = dtu_ctrl_pkg::PENDING;
        else
          next_state = dtu_ctrl_pkg::HAVE_RESET;
      end
      // sticks until the next reset
      dtu_ctrl_pkg::PENDING:    next_state = dtu_ctrl_pkg::PENDING;
      default:                  next_state = dtu_ctrl_pkg::IDLE;
    endcase
  end

  // output level, one cycle behind the state
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      dtu_tdt_dm_havereset <= 1'b0;
    else
      dtu_tdt_dm_havereset <= (cur_state == dtu_ctrl_pkg::HAVE_RESET);
  end

endmodule

// ==== source/dtu_itr_buf.sv ====
// debug instruction register
// valid pulse toward the ifu, one cycle after the dm pulse

`timescale 1ns/1ps

module dtu_itr_buf (
  input  logic                 dtu_cdc_clk,
  input  logic                 cpurst_b,
  input  logic                 dm_itr_vld,
  input  dtu_width_pkg::inst_t dm_itr,
  output dtu_width_pkg::inst_t dtu_ifu_debug_inst,
  output logic                 dtu_ifu_debug_inst_vld
);

  // instruction held until the next dm write
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      dtu_ifu_debug_inst <= '0;
    else if (dm_itr_vld)
      dtu_ifu_debug_inst <= dm_itr;
  end

  // delayed valid
  // lines up with the loaded instruction
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
      dtu_ifu_debug_inst_vld <= 1'b0;
    else
      dtu_ifu_debug_inst_vld <= dm_itr_vld;
  end

endmodule

// ==== source/dtu_abs_reg_read.sv ====
// abstract register access path
// stage 1 captures the dm write flag and data
// stage 2 registers the read source picked by the flag
// stage 3 loads the response data with the ready pulse

`timescale 1ns/1ps

module dtu_abs_reg_read (
  input  logic                    dtu_cdc_clk,
  input  logic                    cpurst_b,
  input  logic                    dm_wr_vld,
  input  dtu_width_pkg::reg_sel_t dm_wr_flg,
  input  dtu_width_pkg::xlen_t    dm_wdata,
  input  dtu_width_pkg::xlen_t    dscratch0,
  input  dtu_width_pkg::xlen_t    cp0_satp,
  input  dtu_width_pkg::pa_t      latest_pc,
  output logic                    tdt_dm_wr_vld,
  output logic                    dtu_tdt_dm_wr_ready,
  output dtu_width_pkg::reg_sel_t tdt_dm_wr_flg,
  output dtu_width_pkg::xlen_t    tdt_dm_wdata,
  output dtu_width_pkg::xlen_t    dtu_tdt_dm_rx_data
);

  // stage 2 valid and data
  logic                 rd_vld_q;
  dtu_width_pkg::xlen_t rdata_q;
  // mux out
  dtu_width_pkg::xlen_t rdata_sel;

  // ====================
  // stage 1 capture
  // ====================
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      tdt_dm_wr_vld <= 1'b0;
      tdt_dm_wr_flg <= '0;
      tdt_dm_wdata  <= '0;
    end
    else
    begin
      tdt_dm_wr_vld <= dm_wr_vld;
      if (dm_wr_vld)
      begin
        tdt_dm_wr_flg <= dm_wr_flg;
        tdt_dm_wdata  <= dm_wdata;
      end
    end
  end

  // read source by captured flag
  always_comb
  begin
    case (tdt_dm_wr_flg)
      dtu_ctrl_pkg::SEL_DSCRATCH0: rdata_sel = dscratch0;
      dtu_ctrl_pkg::SEL_ZERO:      rdata_sel = '0;
      dtu_ctrl_pkg::SEL_PC:
        rdata_sel = {{(dtu_width_pkg::XLEN - dtu_width_pkg::PA_WIDTH){1'b0}}, latest_pc};
      dtu_ctrl_pkg::SEL_SATP:      rdata_sel = cp0_satp;
      default:                     rdata_sel = '0;
    endcase
  end

  // ====================
  // stage 2 and 3
  // ====================
  always_ff @(posedge dtu_cdc_clk or negedge cpurst_b)
  begin
    if (!cpurst_b)
    begin
      rd_vld_q            <= 1'b0;
      rdata_q             <= '0;
      dtu_tdt_dm_wr_ready <= 1'b0;
      dtu_tdt_dm_rx_data  <= '0;
    end
    else
    begin
      rd_vld_q            <= tdt_dm_wr_vld;
      // no back-pressure, each stage just moves on
      dtu_tdt_dm_wr_ready <= rd_vld_q;
      if (tdt_dm_wr_vld)
        rdata_q <= rdata_sel;
      if (rd_vld_q)
        dtu_tdt_dm_rx_data <= rdata_q;
    end
  end

endmodule

// ==== source/dtu_cdc_top.sv ====
// top level of the core-side debug transport bridge
// dm level sync, halt control, have-reset fsm
// debug instruction buffer, abstract register read path

`timescale 1ns/1ps

module dtu_cdc_top #(
  parameter int STAGES = 2
) (
  input  logic                    dtu_cdc_clk,
  input  logic                    cpurst_b,
  input  logic                    dm_halt_req,
  input  logic                    dm_async_halt_req,
  input  logic                    dm_halt_on_reset,
  input  logic                    dm_resume_req,
  input  logic                    dm_ack_havereset,
  input  logic                    dm_itr_vld,
  input  logic                    dm_wr_vld,
  input  dtu_width_pkg::inst_t    dm_itr,
  input  dtu_width_pkg::reg_sel_t dm_wr_flg,
  input  dtu_width_pkg::xlen_t    dm_wdata,
  input  logic                    rtu_dbgon,
  input  logic                    rtu_retire_vld,
  input  logic                    rtu_retire_debug_expt_vld,
  input  dtu_width_pkg::xlen_t    dscratch0,
  input  dtu_width_pkg::xlen_t    cp0_satp,
  input  dtu_width_pkg::pa_t      latest_pc,
  output logic                    dtu_rtu_sync_halt_req,
  output logic                    dtu_rtu_async_halt_req,
  output logic                    async_halt_req_wakeup,
  output logic                    dtu_rtu_resume_req,
  output logic                    dtu_ifu_halt_on_reset,
  output logic                    dtu_ifu_debug_inst_vld,
  output logic                    tdt_dm_wr_vld,
  output logic                    dtu_tdt_dm_wr_ready,
  output logic                    dtu_tdt_dm_halted,
  output logic                    dtu_tdt_dm_itr_done,
  output logic                    dtu_tdt_dm_retire_debug_expt_vld,
  output logic                    dtu_tdt_dm_havereset,
  output dtu_width_pkg::inst_t    dtu_ifu_debug_inst,
  output dtu_width_pkg::reg_sel_t tdt_dm_wr_flg,
  output dtu_width_pkg::xlen_t    tdt_dm_wdata,
  output dtu_width_pkg::xlen_t    dtu_tdt_dm_rx_data
);

  // sync halt, async halt, halt-on-reset
  localparam int WIDTH = 3;

  logic [WIDTH-1:0] dm_lvl;
  logic [WIDTH-1:0] sync_lvl;

  // ====================
  // dm request levels
  // ====================
  assign dm_lvl = {dm_halt_on_reset, dm_async_halt_req, dm_halt_req};

  dtu_lvl_sync #(
    .WIDTH  (WIDTH),
    .STAGES (STAGES)
  ) x_lvl_sync (
    .dtu_cdc_clk (dtu_cdc_clk),
    .cpurst_b    (cpurst_b),
    .src_lvl     (dm_lvl),
    .dst_lvl     (sync_lvl)
  );

  // levels go straight to the core
  assign dtu_rtu_sync_halt_req = sync_lvl[0];
  assign dtu_ifu_halt_on_reset = sync_lvl[2];

  // async halt pulses, resume and status
  dtu_halt_ctrl x_halt_ctrl (
    .dtu_cdc_clk                      (dtu_cdc_clk),
    .cpurst_b                         (cpurst_b),
    .async_lvl                        (sync_lvl[1]),
    .dm_resume_req                    (dm_resume_req),
    .rtu_dbgon                        (rtu_dbgon),
    .rtu_retire_vld                   (rtu_retire_vld),
    .rtu_retire_debug_expt_vld        (rtu_retire_debug_expt_vld),
    .async_halt_req_wakeup            (async_halt_req_wakeup),
    .dtu_rtu_async_halt_req           (dtu_rtu_async_halt_req),
    .dtu_rtu_resume_req               (dtu_rtu_resume_req),
    .dtu_tdt_dm_halted                (dtu_tdt_dm_halted),
    .dtu_tdt_dm_itr_done              (dtu_tdt_dm_itr_done),
    .dtu_tdt_dm_retire_debug_expt_vld (dtu_tdt_dm_retire_debug_expt_vld)
  );

  // ====================
  // reset status
  // ====================
  dtu_havereset_fsm x_havereset_fsm (
    .dtu_cdc_clk          (dtu_cdc_clk),
    .cpurst_b             (cpurst_b),
    .dm_ack_havereset     (dm_ack_havereset),
    .dtu_tdt_dm_havereset (dtu_tdt_dm_havereset)
  );

  // ====================
  // debug data paths
  // ====================
  dtu_itr_buf x_itr_buf (
    .dtu_cdc_clk            (dtu_cdc_clk),
    .cpurst_b               (cpurst_b),
    .dm_itr_vld             (dm_itr_vld),
    .dm_itr                 (dm_itr),
    .dtu_ifu_debug_inst     (dtu_ifu_debug_inst),
    .dtu_ifu_debug_inst_vld (dtu_ifu_debug_inst_vld)
  );

  dtu_abs_reg_read x_abs_reg_read (
    .dtu_cdc_clk         (dtu_cdc_clk),
    .cpurst_b            (cpurst_b),
    .dm_wr_vld           (dm_wr_vld),
    .dm_wr_flg           (dm_wr_flg),
    .dm_wdata            (dm_wdata),
    .dscratch0           (dscratch0),
    .cp0_satp            (cp0_satp),
    .latest_pc           (latest_pc),
    .tdt_dm_wr_vld       (tdt_dm_wr_vld),
    .dtu_tdt_dm_wr_ready (dtu_tdt_dm_wr_ready),
    .tdt_dm_wr_flg       (tdt_dm_wr_flg),
    .tdt_dm_wdata        (tdt_dm_wdata),
    .dtu_tdt_dm_rx_data  (dtu_tdt_dm_rx_data)
  );

endmodule

// ==== dv/dtu_cdc_tb.sv ====
// testbench for the core-side debug transport bridge
// table of operations applied in a loop
// drive and check tasks per operation kind
// watchdog and closing error summary

`timescale 1ns/1ps

module dtu_cdc_tb;

  localparam int NUM_ROWS = 17;

  typedef enum logic [2:0] {OP_READ, OP_ITR, OP_HALT, OP_ASYNC, OP_STATUS, OP_ACK} op_e;

  // status row bits {resume, expt, retire, dbgon}
  // status row exp_bits {resume, expt, itr_done, halted}
  // halt row bits and exp_bits {hor, halt}
  typedef struct packed {
    op_e         kind;
    logic [3:0]  bits;
    logic [3:0]  exp_bits;
    logic [3:0]  count;
    logic [1:0]  flag;
    logic [63:0] data;
    logic [39:0] pc;
  } row_t;

  logic dtu_cdc_clk;
  logic cpurst_b;
  logic dm_halt_req;
  logic dm_async_halt_req;
  logic dm_halt_on_reset;
  logic dm_resume_req;
  logic dm_ack_havereset;
  logic dm_itr_vld;
  logic dm_wr_vld;
  dtu_width_pkg::inst_t dm_itr;
  dtu_width_pkg::reg_sel_t dm_wr_flg;
  dtu_width_pkg::xlen_t dm_wdata;
  logic rtu_dbgon;
  logic rtu_retire_vld;
  logic rtu_retire_debug_expt_vld;
  dtu_width_pkg::xlen_t dscratch0;
  dtu_width_pkg::xlen_t cp0_satp;
  dtu_width_pkg::pa_t latest_pc;
  logic dtu_rtu_sync_halt_req;
  logic dtu_rtu_async_halt_req;
  logic async_halt_req_wakeup;
  logic dtu_rtu_resume_req;
  logic dtu_ifu_halt_on_reset;
  logic dtu_ifu_debug_inst_vld;
  logic tdt_dm_wr_vld;
  logic dtu_tdt_dm_wr_ready;
  logic dtu_tdt_dm_halted;
  logic dtu_tdt_dm_itr_done;
  logic dtu_tdt_dm_retire_debug_expt_vld;
  logic dtu_tdt_dm_havereset;
  dtu_width_pkg::inst_t dtu_ifu_debug_inst;
  dtu_width_pkg::reg_sel_t tdt_dm_wr_flg;
  dtu_width_pkg::xlen_t tdt_dm_wdata;
  dtu_width_pkg::xlen_t dtu_tdt_dm_rx_data;

  row_t rows [0:NUM_ROWS-1];
  int seed = 19989;
  int check_cnt = 0;
  int err_cnt = 0;
  // halt levels {hor, halt} expected from the previous halt row
  logic [1:0] lvl_prev = 2'b00;

  dtu_cdc_top #(.STAGES(2)) dut_i (.*);

  // 8 ns clock
  initial dtu_cdc_clk = 1'b0;
  always #4 dtu_cdc_clk = ~dtu_cdc_clk;

  // ====================
  // helpers
  // ====================
  task automatic check_val(input string name, input logic [63:0] act, input logic [63:0] exp);
    check_cnt++;
    assert (act === exp)
    else
    begin
      err_cnt++;
      $display("Mismatch at %0t ns: %s expected %0h actual %0h", $time, name, exp, act);
    end
  endtask

  // read source picked by each flag value
  function automatic dtu_width_pkg::xlen_t expected_read(input logic [1:0] flg,
      input logic [63:0] ds, input logic [63:0] satp, input logic [39:0] pc);
    case (flg)
      2'd0: return ds;
      2'd1: return 64'h0;
      2'd2: return {24'h0, pc};
      default: return satp;
    endcase
  endfunction

  task automatic set_row(input int idx, input op_e kind, input logic [3:0] bits,
      input logic [3:0] exp_bits, input logic [3:0] count, input logic [1:0] flag,
      input logic [63:0] data, input logic [39:0] pc);
    rows[idx] = {kind, bits, exp_bits, count, flag, data, pc};
  endtask

  // ====================
  // per-kind tasks
  // ====================
  // back-to-back burst of count requests
  // flag and data step by one per request
  task automatic read_burst(input row_t r);
    logic [1:0]  flg [0:7];
    logic [63:0] wd [0:7];
    logic [63:0] rd [0:7];
    logic [63:0] ds;
    logic [63:0] satp;
    int n;
    n = int'(r.count);
    ds = {$random(seed), $random(seed)};
    satp = {$random(seed), $random(seed)};
    dscratch0 = ds;
    cp0_satp = satp;
    latest_pc = r.pc;
    for (int k = 0; k < n; k++)
    begin
      flg[k] = r.flag + 2'(k);
      wd[k] = r.data + 64'(k);
      rd[k] = expected_read(flg[k], ds, satp, r.pc);
    end
    for (int c = 0; c <= n + 3; c++)
    begin
      // echo one edge after the request
      if (c >= 1)
        check_val("tdt_dm_wr_vld", 64'(tdt_dm_wr_vld), 64'(c - 1 < n));
      if (c >= 1 && c - 1 < n)
      begin
        check_val("tdt_dm_wr_flg", 64'(tdt_dm_wr_flg), 64'(flg[c-1]));
        check_val("tdt_dm_wdata", tdt_dm_wdata, wd[c-1]);
      end
      // response two edges after the echo
      if (c >= 1)
        check_val("dtu_tdt_dm_wr_ready", 64'(dtu_tdt_dm_wr_ready), 64'(c >= 3 && c - 3 < n));
      if (c >= 3 && c - 3 < n)
        check_val("dtu_tdt_dm_rx_data", dtu_tdt_dm_rx_data, rd[c-3]);
      dm_wr_vld = (c < n);
      if (c < n)
      begin
        dm_wr_flg = flg[c];
        dm_wdata = wd[c];
      end
      if (c < n + 3)
        @(negedge dtu_cdc_clk);
    end
  endtask

  task automatic load_instruction(input row_t r);
    dm_itr_vld = 1'b1;
    dm_itr = r.data[31:0];
    @(negedge dtu_cdc_clk);
    dm_itr_vld = 1'b0;
    // new value on the bus must not load without valid
    dm_itr = ~r.data[31:0];
    check_val("dtu_ifu_debug_inst_vld", 64'(dtu_ifu_debug_inst_vld), 64'h1);
    check_val("dtu_ifu_debug_inst", 64'(dtu_ifu_debug_inst), 64'(r.data[31:0]));
    @(negedge dtu_cdc_clk);
    check_val("dtu_ifu_debug_inst_vld", 64'(dtu_ifu_debug_inst_vld), 64'h0);
    check_val("dtu_ifu_debug_inst", 64'(dtu_ifu_debug_inst), 64'(r.data[31:0]));
  endtask

  // levels show up after the second edge
  task automatic apply_halt_levels(input row_t r);
    dm_halt_req = r.bits[0];
    dm_halt_on_reset = r.bits[1];
    @(negedge dtu_cdc_clk);
    check_val("dtu_rtu_sync_halt_req", 64'(dtu_rtu_sync_halt_req), 64'(lvl_prev[0]));
    check_val("dtu_ifu_halt_on_reset", 64'(dtu_ifu_halt_on_reset), 64'(lvl_prev[1]));
    @(negedge dtu_cdc_clk);
    check_val("dtu_rtu_sync_halt_req", 64'(dtu_rtu_sync_halt_req), 64'(r.exp_bits[0]));
    check_val("dtu_ifu_halt_on_reset", 64'(dtu_ifu_halt_on_reset), 64'(r.exp_bits[1]));
    lvl_prev = r.exp_bits[1:0];
  endtask

  // one wakeup then one halt pulse per rising level
  task automatic hold_async_halt();
    dm_async_halt_req = 1'b1;
    for (int c = 1; c <= 7; c++)
    begin
      @(negedge dtu_cdc_clk);
      check_val("async_halt_req_wakeup", 64'(async_halt_req_wakeup), 64'(c == 2));
      check_val("dtu_rtu_async_halt_req", 64'(dtu_rtu_async_halt_req), 64'(c == 3));
    end
    dm_async_halt_req = 1'b0;
    repeat (4)
    begin
      @(negedge dtu_cdc_clk);
      check_val("async_halt_req_wakeup", 64'(async_halt_req_wakeup), 64'h0);
      check_val("dtu_rtu_async_halt_req", 64'(dtu_rtu_async_halt_req), 64'h0);
    end
  endtask

  task automatic drive_status(input row_t r);
    rtu_dbgon = r.bits[0];
    rtu_retire_vld = r.bits[1];
    rtu_retire_debug_expt_vld = r.bits[2];
    dm_resume_req = r.bits[3];
    @(negedge dtu_cdc_clk);
    check_val("dtu_tdt_dm_halted", 64'(dtu_tdt_dm_halted), 64'(r.exp_bits[0]));
    check_val("dtu_tdt_dm_itr_done", 64'(dtu_tdt_dm_itr_done), 64'(r.exp_bits[1]));
    check_val("dtu_tdt_dm_retire_debug_expt_vld", 64'(dtu_tdt_dm_retire_debug_expt_vld),
              64'(r.exp_bits[2]));
    check_val("dtu_rtu_resume_req", 64'(dtu_rtu_resume_req), 64'(r.exp_bits[3]));
    rtu_dbgon = 1'b0;
    rtu_retire_vld = 1'b0;
    rtu_retire_debug_expt_vld = 1'b0;
    dm_resume_req = 1'b0;
    @(negedge dtu_cdc_clk);
    check_val("dtu_tdt_dm_halted", 64'(dtu_tdt_dm_halted), 64'h0);
    check_val("dtu_tdt_dm_itr_done", 64'(dtu_tdt_dm_itr_done), 64'h0);
    check_val("dtu_tdt_dm_retire_debug_expt_vld", 64'(dtu_tdt_dm_retire_debug_expt_vld), 64'h0);
    check_val("dtu_rtu_resume_req", 64'(dtu_rtu_resume_req), 64'h0);
  endtask

  task automatic ack_havereset();
    int cnt;
    cnt = 0;
    check_val("dtu_tdt_dm_havereset", 64'(dtu_tdt_dm_havereset), 64'h1);
    dm_ack_havereset = 1'b1;
    @(negedge dtu_cdc_clk);
    dm_ack_havereset = 1'b0;
    cnt = 1;
    // allow up to two cycles for the drop
    while (dtu_tdt_dm_havereset && cnt < 2)
    begin
      @(negedge dtu_cdc_clk);
      cnt++;
    end
    check_val("dtu_tdt_dm_havereset", 64'(dtu_tdt_dm_havereset), 64'h0);
    repeat (4)
    begin
      @(negedge dtu_cdc_clk);
      check_val("dtu_tdt_dm_havereset", 64'(dtu_tdt_dm_havereset), 64'h0);
    end
  endtask

  // ====================
  // main sequence
  // ====================
  initial
  begin
    row_t r;
    cpurst_b = 1'b0;
    dm_halt_req = 1'b0;
    dm_async_halt_req = 1'b0;
    dm_halt_on_reset = 1'b0;
    dm_resume_req = 1'b0;
    dm_ack_havereset = 1'b0;
    dm_itr_vld = 1'b0;
    dm_wr_vld = 1'b0;
    dm_itr = '0;
    dm_wr_flg = '0;
    dm_wdata = '0;
    rtu_dbgon = 1'b0;
    rtu_retire_vld = 1'b0;
    rtu_retire_debug_expt_vld = 1'b0;
    dscratch0 = '0;
    cp0_satp = '0;
    latest_pc = '0;
    // kind, bits, exp_bits, count, flag, data, pc
    set_row(0, OP_READ, 4'h0, 4'h0, 4'd1, 2'd0, 64'h1111_0000_0000_0001, 40'h00_8000_1000);
    set_row(1, OP_READ, 4'h0, 4'h0, 4'd1, 2'd1, 64'h2222_0000_0000_0002, 40'h00_8000_1004);
    set_row(2, OP_READ, 4'h0, 4'h0, 4'd1, 2'd2, 64'h3333_0000_0000_0003, 40'hab_cdef_0124);
    set_row(3, OP_READ, 4'h0, 4'h0, 4'd1, 2'd3, 64'h4444_0000_0000_0004, 40'h00_8000_100c);
    set_row(4, OP_ITR, 4'h0, 4'h0, 4'd0, 2'd0, 64'h0000_0000_0010_0073, 40'h0);
    set_row(5, OP_HALT, 4'h1, 4'h1, 4'd0, 2'd0, 64'h0, 40'h0);
    set_row(6, OP_HALT, 4'h3, 4'h3, 4'd0, 2'd0, 64'h0, 40'h0);
    set_row(7, OP_HALT, 4'h2, 4'h2, 4'd0, 2'd0, 64'h0, 40'h0);
    set_row(8, OP_HALT, 4'h0, 4'h0, 4'd0, 2'd0, 64'h0, 40'h0);
    set_row(9, OP_ASYNC, 4'h0, 4'h0, 4'd0, 2'd0, 64'h0, 40'h0);
    // retire in debug mode, retire outside it, resume with exception
    set_row(10, OP_STATUS, 4'h3, 4'h3, 4'd0, 2'd0, 64'h0, 40'h0);
    set_row(11, OP_STATUS, 4'h2, 4'h0, 4'd0, 2'd0, 64'h0, 40'h0);
    set_row(12, OP_STATUS, 4'hd, 4'hd, 4'd0, 2'd0, 64'h0, 40'h0);
    set_row(13, OP_READ, 4'h0, 4'h0, 4'd4, 2'd0, 64'h5555_aaaa_0000_0010, 40'h12_3456_7898);
    set_row(14, OP_ITR, 4'h0, 4'h0, 4'd0, 2'd0, 64'h0000_0000_7b20_0073, 40'h0);
    set_row(15, OP_READ, 4'h0, 4'h0, 4'd3, 2'd2, 64'h6666_0000_ffff_fff0, 40'hff_ffff_fffc);
    set_row(16, OP_ACK, 4'h0, 4'h0, 4'd0, 2'd0, 64'h0, 40'h0);

    // 2 reset cycles then release on a falling edge
    repeat (2) @(posedge dtu_cdc_clk);
    @(negedge dtu_cdc_clk);
    cpurst_b = 1'b1;
    @(negedge dtu_cdc_clk);
    check_val("dtu_tdt_dm_havereset", 64'(dtu_tdt_dm_havereset), 64'h0);
    repeat (2) @(negedge dtu_cdc_clk);
    check_val("dtu_tdt_dm_havereset", 64'(dtu_tdt_dm_havereset), 64'h1);

    for (int i = 0; i < NUM_ROWS; i++)
    begin
      r = rows[i];
      case (r.kind)
        OP_READ:   read_burst(r);
        OP_ITR:    load_instruction(r);
        OP_HALT:   apply_halt_levels(r);
        OP_ASYNC:  hold_async_halt();
        OP_STATUS: drive_status(r);
        default:   ack_havereset();
      endcase
    end

    $display("checks: %0d, errors: %0d", check_cnt, err_cnt);
    if (err_cnt == 0)
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

  // watchdog allows 12 cycles per row plus margin
  initial
  begin
    #((NUM_ROWS * 12 + 50) * 8);
    $display("timeout: the test sequence did not finish in time");
    $display("sim failed");
    $finish;
  end

endmodule

// ==== project.f ====
source/dtu_width_pkg.sv
source/dtu_ctrl_pkg.sv
source/dtu_lvl_sync.sv
source/dtu_halt_ctrl.sv
source/dtu_havereset_fsm.sv
source/dtu_itr_buf.sv
source/dtu_abs_reg_read.sv
source/dtu_cdc_top.sv
dv/dtu_cdc_tb.sv

// ==== run.sh ====
#!/bin/sh
# build and run the testbench with Verilator, then search the log for failure
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary -f project.f --top-module dtu_cdc_tb -o dtu_cdc_sim &&
  ./obj_dir/dtu_cdc_sim > sim.log 2>&1 ;
cat sim.log 2>/dev/null
test -f sim.log && ! grep -q "sim failed" sim.log && grep -q "checks:" sim.log &&
  echo "run.sh: simulation ok" || { echo "run.sh: simulation failed"; exit 1; }
